/* verilog.f */
rtl/lcd_pkg.sv
rtl/lcd_cmd_fifo.sv
rtl/lcd_bus_writer.sv
rtl/lcd_draw_sequencer.sv
rtl/lcd_controller.sv
test/lcd_clock_gen.sv
test/tb_lcd_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module tb_lcd_controller --Mdir obj_dir -o tb_lcd_controller
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_lcd_controller > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* test/tb_lcd_controller.sv */
`timescale 1ns/100ps

module tb_lcd_controller;

    // Panel protocol values.
    localparam logic [7:0] CMD_SOFT_RESET   = 8'h01;
    localparam logic [7:0] CMD_SLEEP_OUT    = 8'h11;
    localparam logic [7:0] CMD_PIXEL_FORMAT = 8'h3A;
    localparam logic [7:0] CMD_DISPLAY_ON   = 8'h29;
    localparam logic [7:0] CMD_COLUMN_ADDR  = 8'h2A;
    localparam logic [7:0] CMD_PAGE_ADDR    = 8'h2B;
    localparam logic [7:0] CMD_MEMORY_WRITE = 8'h2C;
    localparam int RST_LOW  = 8;
    localparam int WR_LOW   = 2;
    // Worst case words: init, fixed, 12 random and one busy test.
    localparam longint MAX_WORDS  = 5 + 20 + 13 * (11 + 64);
    localparam longint TIMEOUT_NS = 4 * MAX_WORDS * 50 + 50000;

    logic        clk_20MHz;
    logic        rst_n;
    logic        draw_go;
    logic [15:0] x_start, x_end, y_start, y_end, color;
    logic        busy, lcd_rst, bl_ctr, lcd_cs, lcd_rs, lcd_wr, lcd_rd;
    logic [15:0] lcd_data;

    logic [16:0] exp_q[$];     // Expected {RS, DATA} in bus order.
    logic [15:0] lfsr = 16'd19653;
    string       cur_test;
    int          errors = 0;
    int          failed = 0;
    int          tests = 0;
    int          word_count = 0;
    int          err0, word0;
    int          rst_low_cnt = 0;
    logic        bl_at_init = 1'b0;
    logic        wr_prev = 1'b1;
    int          low_cnt = 0;
    logic [16:0] low_word;
    logic [16:0] got;
    int          xs, ys, w, h, c, i;

    lcd_clock_gen i_lcd_clock_gen (.clk_20MHz(clk_20MHz), .rst_n(rst_n));

    lcd_controller i_lcd_controller (
        .clk_20MHz (clk_20MHz), .rst_n (rst_n), .draw_go (draw_go),
        .x_start (x_start), .x_end (x_end), .y_start (y_start), .y_end (y_end),
        .color (color), .busy (busy), .LCD_RST (lcd_rst), .BL_CTR (bl_ctr),
        .LCD_CS (lcd_cs), .LCD_RS (lcd_rs), .LCD_WR (lcd_wr), .LCD_RD (lcd_rd),
        .LCD_DATA (lcd_data)
    );

    ////////////////////////////////////////
    // Stimulus helpers.
    ////////////////////////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr); // One step per bit.
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic expect_word(input logic rs, input logic [15:0] d);
        exp_q.push_back({rs, d});
    endtask

    // Reference sequence of one rectangle fill.
    task automatic model_rect(input int x0, input int x1, input int y0, input int y1,
                              input logic [15:0] col);
        expect_word(1'b0, {8'h00, CMD_COLUMN_ADDR});
        expect_word(1'b1, 16'((x0 >> 8) & 255));
        expect_word(1'b1, 16'(x0 & 255));
        expect_word(1'b1, 16'((x1 >> 8) & 255));
        expect_word(1'b1, 16'(x1 & 255));
        expect_word(1'b0, {8'h00, CMD_PAGE_ADDR});
        expect_word(1'b1, 16'((y0 >> 8) & 255));
        expect_word(1'b1, 16'(y0 & 255));
        expect_word(1'b1, 16'((y1 >> 8) & 255));
        expect_word(1'b1, 16'(y1 & 255));
        expect_word(1'b0, {8'h00, CMD_MEMORY_WRITE});
        for (int p = 0; p < (x1 - x0 + 1) * (y1 - y0 + 1); p++) expect_word(1'b1, col);
    endtask

    task automatic pulse_go(input int x0, input int x1, input int y0, input int y1,
                            input logic [15:0] col);
        @(posedge clk_20MHz);
        #5;
        x_start = 16'(x0);
        x_end   = 16'(x1);
        y_start = 16'(y0);
        y_end   = 16'(y1);
        color   = col;
        draw_go = 1'b1;
        @(posedge clk_20MHz);
        #5 draw_go = 1'b0; // One-cycle strobe.
    endtask

    task automatic draw_rect(input int x0, input int y0, input int wd, input int ht,
                             input logic [15:0] col);
        model_rect(x0, x0 + wd - 1, y0, y0 + ht - 1, col);
        pulse_go(x0, x0 + wd - 1, y0, y0 + ht - 1, col);
    endtask

    task automatic wait_done();
        while (busy) @(negedge clk_20MHz); // Busy sampled mid-cycle.
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err0     = errors;
        word0    = word_count;
    endtask

    task automatic finish_test();
        if (exp_q.size() != 0) begin
            $display("** Error %s expected %0d words actual %0d", cur_test,
                     word_count - word0 + exp_q.size(), word_count - word0);
            errors++;
            exp_q.delete();
        end
        tests++;
        if (errors != err0) failed++;
        $display("%-14s %s, %0d words", cur_test, (errors == err0) ? "ok" : "failed",
                 word_count - word0);
    endtask

    ////////////////////////////////////////
    // Bus monitor, sampled mid-cycle.
    ////////////////////////////////////////
    always @(negedge clk_20MHz) begin
        if (rst_n) begin
            if (!lcd_rst) rst_low_cnt++;
            if (!lcd_rd) begin
                $display("LCD_RD fell in test %s", cur_test);
                errors++;
            end
            if (!lcd_wr) begin
                if (lcd_cs) begin
                    $display("CS high while WR low in test %s", cur_test);
                    errors++;
                end
                if (!lcd_rst) begin
                    $display("write while panel in reset in test %s", cur_test);
                    errors++;
                end
                if (low_cnt > 0 && {lcd_rs, lcd_data} != low_word) begin
                    $display("RS or DATA changed while WR low in test %s", cur_test);
                    errors++;
                end
                low_word = {lcd_rs, lcd_data};
                low_cnt++;
            end else if (!wr_prev) begin
                // WR just rose, the word is complete.
                got = low_word;
                word_count++;
                if (word_count == 5) bl_at_init = bl_ctr;
                if (low_cnt != WR_LOW) begin
                    $display("** Error %s expected %0d actual %0d", cur_test, WR_LOW, low_cnt);
                    errors++;
                end
                if (!got[16] && got[15:8] != 8'h00) begin
                    $display("command word with nonzero upper byte in test %s", cur_test);
                    errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("unexpected bus word %h in test %s", got, cur_test);
                    errors++;
                end else if (exp_q[0] != got) begin
                    $display("** Error %s expected %h actual %h", cur_test, exp_q[0], got);
                    errors++;
                    void'(exp_q.pop_front());
                end else begin
                    void'(exp_q.pop_front());
                end
                low_cnt = 0;
            end
            wr_prev = lcd_wr;
        end
    end

    // Watchdog.
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired in test %s, the DUT stopped making progress", cur_test);
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////
    initial begin
        draw_go = 1'b0;
        x_start = 16'd0;
        x_end   = 16'd0;
        y_start = 16'd0;
        y_end   = 16'd0;
        color   = 16'd0;

        start_test("startup");
        expect_word(1'b0, {8'h00, CMD_SOFT_RESET});
        expect_word(1'b0, {8'h00, CMD_SLEEP_OUT});
        expect_word(1'b0, {8'h00, CMD_PIXEL_FORMAT});
        expect_word(1'b1, 16'h0055);
        expect_word(1'b0, {8'h00, CMD_DISPLAY_ON});
        @(posedge rst_n);
        @(posedge clk_20MHz);
        wait_done();
        if (rst_low_cnt < RST_LOW) begin
            $display("** Error %s expected %0d actual %0d", cur_test, RST_LOW, rst_low_cnt);
            errors++;
        end
        if (!bl_at_init) begin
            $display("backlight still off when the last init word left the bus");
            errors++;
        end
        finish_test();

        start_test("fixed_rect");
        draw_rect(2, 3, 3, 3, 16'hF800);
        wait_done();
        finish_test();

        for (i = 0; i < 12; i++) begin
            take_bits(10, xs);
            take_bits(9, ys);
            take_bits(3, w);
            take_bits(3, h);
            take_bits(16, c);
            start_test($sformatf("random_%0d", i));
            draw_rect(xs % 792, ys % 472, w + 1, h + 1, 16'(c));
            wait_done();
            finish_test();
        end

        start_test("go_while_busy");
        draw_rect(100, 200, 4, 2, 16'h07E0);
        repeat (6) @(negedge clk_20MHz);
        if (!busy) begin
            $display("busy low too early in test %s", cur_test);
            errors++;
        end
        pulse_go(0, 7, 0, 7, 16'h001F); // Must be dropped.
        wait_done();
        repeat (20) @(negedge clk_20MHz);
        if (busy) begin
            $display("ignored strobe started a second fill in test %s", cur_test);
            errors++;
        end
        finish_test();

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* test/lcd_clock_gen.sv */
`timescale 1ns/100ps

module lcd_clock_gen (
    output logic clk_20MHz,
    output logic rst_n
);

    // 50 ns period.
    initial begin
        clk_20MHz = 1'b0;
        forever #25 clk_20MHz = ~clk_20MHz;
    end

    // Reset low for four cycles.
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk_20MHz);
        #5 rst_n = 1'b1; // Released clear of the edge.
    end

endmodule

/* rtl/lcd_controller.sv */
`timescale 1ns/100ps

module lcd_controller import lcd_pkg::*; (
    input  logic        clk_20MHz,
    input  logic        rst_n,
    input  logic        draw_go,
    input  logic [15:0] x_start,
    input  logic [15:0] x_end,
    input  logic [15:0] y_start,
    input  logic [15:0] y_end,
    input  logic [15:0] color,
    output logic        busy,
    // Panel pins, active low controls.
    output logic        LCD_RST,
    output logic        BL_CTR, // Backlight enable.
    output logic        LCD_CS,
    output logic        LCD_RS,
    output logic        LCD_WR,
    output logic        LCD_RD,
    output logic [15:0] LCD_DATA
);

    bus_entry_t push_entry;
    bus_entry_t head_entry;
    logic       push_en;
    logic       pop_en;
    logic       full;
    logic       empty;
    logic       bus_idle;

    // No GRAM read-back.
    assign LCD_RD = 1'b1;

    ////////////////////////////////////////
    // Producer, buffer, consumer.
    ////////////////////////////////////////
    lcd_draw_sequencer i_lcd_draw_sequencer (
        .clk_20MHz  (clk_20MHz),
        .rst_n      (rst_n),
        .draw_go    (draw_go),
        .x_start    (x_start),
        .x_end      (x_end),
        .y_start    (y_start),
        .y_end      (y_end),
        .color      (color),
        .full       (full),
        .empty      (empty),
        .bus_idle   (bus_idle),
        .push_en    (push_en),
        .push_entry (push_entry),
        .lcd_rst    (LCD_RST),
        .backlight  (BL_CTR),
        .busy       (busy)
    );

    lcd_cmd_fifo i_lcd_cmd_fifo (
        .clk_20MHz  (clk_20MHz),
        .rst_n      (rst_n),
        .push_en    (push_en),
        .push_entry (push_entry),
        .pop_en     (pop_en),
        .head_entry (head_entry),
        .full       (full),
        .empty      (empty)
    );

    lcd_bus_writer i_lcd_bus_writer (
        .clk_20MHz  (clk_20MHz),
        .rst_n      (rst_n),
        .empty      (empty),
        .head_entry (head_entry),
        .pop_en     (pop_en),
        .bus_idle   (bus_idle),
        .lcd_cs     (LCD_CS),
        .lcd_rs     (LCD_RS),
        .lcd_wr     (LCD_WR),
        .lcd_data   (LCD_DATA)
    );

endmodule

/* rtl/lcd_draw_sequencer.sv */
`timescale 1ns/100ps

module lcd_draw_sequencer import lcd_pkg::*; (
    input  logic        clk_20MHz,
    input  logic        rst_n,
    input  logic        draw_go,
    input  logic [15:0] x_start,
    input  logic [15:0] x_end,
    input  logic [15:0] y_start,
    input  logic [15:0] y_end,
    input  logic [15:0] color,
    input  logic        full,
    input  logic        empty,
    input  logic        bus_idle,
    output logic        push_en,
    output bus_entry_t  push_entry,
    output logic        lcd_rst,
    output logic        backlight,
    output logic        busy
);

    logic [3:0]  state;
    logic [15:0] wait_cnt;   // Reset pulse and settle timer.
    logic [2:0]  step;       // Word index inside INIT, COLUMN, PAGE.
    logic [15:0] x_start_q;
    logic [15:0] x_end_q;
    logic [15:0] y_start_q;
    logic [15:0] y_end_q;
    logic [15:0] color_q;
    logic [15:0] col_cnt;
    logic [15:0] row_cnt;
    logic        push_state;
    logic        last_step;
    logic        last_col;
    logic        last_row;

    // Command word, upper byte cleared.
    function automatic bus_entry_t cmd_entry(input logic [7:0] code);
        bus_entry_t e;
        e.is_data       = 1'b0;
        e.word.cmd.rsvd = 8'h00;
        e.word.cmd.code = code;
        return e;
    endfunction

    function automatic bus_entry_t data_entry(input logic [15:0] value);
        bus_entry_t e;
        e.is_data  = 1'b1;
        e.word.raw = value;
        return e;
    endfunction

    // Address group: command, start hi, start lo, end hi, end lo.
    function automatic bus_entry_t addr_entry(
        input logic [7:0]  code,
        input logic [15:0] first,
        input logic [15:0] last,
        input logic [2:0]  idx
    );
        bus_entry_t e;
        case (idx)
            3'd0:    e = cmd_entry(code);
            3'd1:    e = data_entry({8'h00, first[15:8]});
            3'd2:    e = data_entry({8'h00, first[7:0]});
            3'd3:    e = data_entry({8'h00, last[15:8]});
            default: e = data_entry({8'h00, last[7:0]});
        endcase
        return e;
    endfunction

    assign push_state = (state == SEQ_INIT)     || (state == SEQ_COLUMN) ||
                        (state == SEQ_PAGE)     || (state == SEQ_MEMWRITE) ||
                        (state == SEQ_PIXELS);
    assign push_en    = push_state && !full; // One word per free cycle.
    assign busy       = (state != SEQ_IDLE); // Low only when fully drained.

    assign last_step = (step == SEQ_LAST_STEP);
    assign last_col  = (col_cnt == x_end_q - x_start_q);
    assign last_row  = (row_cnt == y_end_q - y_start_q);

    ////////////////////////////////////////
    // Word selection.
    ////////////////////////////////////////
    always_comb begin
        push_entry = data_entry(color_q); // PIXELS, and don't-care elsewhere.
        case (state)
            SEQ_INIT: begin
                case (step)
                    3'd0:    push_entry = cmd_entry(CMD_SOFT_RESET);
                    3'd1:    push_entry = cmd_entry(CMD_SLEEP_OUT);
                    3'd2:    push_entry = cmd_entry(CMD_PIXEL_FORMAT);
                    3'd3:    push_entry = data_entry({8'h00, PIXEL_FORMAT_16BIT});
                    default: push_entry = cmd_entry(CMD_DISPLAY_ON);
                endcase
            end
            SEQ_COLUMN:   push_entry = addr_entry(CMD_COLUMN_ADDR, x_start_q, x_end_q, step);
            SEQ_PAGE:     push_entry = addr_entry(CMD_PAGE_ADDR, y_start_q, y_end_q, step);
            SEQ_MEMWRITE: push_entry = cmd_entry(CMD_MEMORY_WRITE);
            default:      ;
        endcase
    end

    // Rectangle sampled on an accepted strobe.
    always_ff @(posedge clk_20MHz) begin
        if (state == SEQ_IDLE && draw_go) begin
            x_start_q <= x_start;
            x_end_q   <= x_end;
            y_start_q <= y_start;
            y_end_q   <= y_end;
            color_q   <= color;
        end
    end

    ////////////////////////////////////////
    // Step machine.
    ////////////////////////////////////////
    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SEQ_RESET_LOW;
            wait_cnt  <= 16'd0;
            step      <= 3'd0;
            col_cnt   <= 16'd0;
            row_cnt   <= 16'd0;
            lcd_rst   <= 1'b0; // Panel held in reset.
            backlight <= 1'b0;
        end else begin
            case (state)
                SEQ_RESET_LOW: begin
                    if (wait_cnt == RST_LOW_CYCLES - 16'd1) begin
                        wait_cnt <= 16'd0;
                        lcd_rst  <= 1'b1; // Release panel.
                        state    <= SEQ_RESET_WAIT;
                    end else begin
                        wait_cnt <= wait_cnt + 16'd1;
                    end
                end
                SEQ_RESET_WAIT: begin
                    if (wait_cnt == RST_WAIT_CYCLES - 16'd1) begin
                        wait_cnt <= 16'd0;
                        step     <= 3'd0;
                        state    <= SEQ_INIT;
                    end else begin
                        wait_cnt <= wait_cnt + 16'd1;
                    end
                end
                SEQ_INIT: begin
                    if (!full) begin
                        if (last_step) begin
                            step      <= 3'd0;
                            backlight <= 1'b1; // Table fully queued.
                            state     <= SEQ_DRAIN;
                        end else begin
                            step <= step + 3'd1;
                        end
                    end
                end
                SEQ_IDLE: begin
                    if (draw_go) begin
                        step  <= 3'd0;
                        state <= SEQ_COLUMN;
                    end
                end
                SEQ_COLUMN, SEQ_PAGE: begin
                    if (!full) begin
                        if (last_step) begin
                            step  <= 3'd0;
                            state <= (state == SEQ_COLUMN) ? SEQ_PAGE : SEQ_MEMWRITE;
                        end else begin
                            step <= step + 3'd1;
                        end
                    end
                end
                SEQ_MEMWRITE: begin
                    if (!full) begin
                        col_cnt <= 16'd0;
                        row_cnt <= 16'd0;
                        state   <= SEQ_PIXELS;
                    end
                end
                SEQ_PIXELS: begin
                    // Row-major walk, column counter innermost.
                    if (!full) begin
                        if (last_col) begin
                            col_cnt <= 16'd0;
                            if (last_row) state <= SEQ_DRAIN;
                            else row_cnt <= row_cnt + 16'd1;
                        end else begin
                            col_cnt <= col_cnt + 16'd1;
                        end
                    end
                end
                SEQ_DRAIN: begin
                    if (empty && bus_idle) state <= SEQ_IDLE; // Last word is out.
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

/* rtl/lcd_bus_writer.sv */
`timescale 1ns/100ps

module lcd_bus_writer import lcd_pkg::*; (
    input  logic        clk_20MHz,
    input  logic        rst_n,
    input  logic        empty,
    input  bus_entry_t  head_entry,
    output logic        pop_en,
    output logic        bus_idle,
    output logic        lcd_cs,
    output logic        lcd_rs,
    output logic        lcd_wr,
    output logic [15:0] lcd_data
);

    logic [1:0] state;
    logic [3:0] phase;     // Cycles left in the current strobe phase.
    bus_entry_t cur_entry; // Word on the bus, held until the next pop.

    assign bus_idle = (state == BW_IDLE);
    assign pop_en   = bus_idle && !empty; // Head taken in this cycle.

    ////////////////////////////////////////
    // Bus decode.
    ////////////////////////////////////////
    assign lcd_rs   = cur_entry.is_data;
    assign lcd_data = cur_entry.is_data ? cur_entry.word.raw
                                        : {8'h00, cur_entry.word.cmd.code}; // Byte command.

    // Latch on pop. Stays stable over the whole strobe and the rising edge.
    always_ff @(posedge clk_20MHz) begin
        if (pop_en) begin
            cur_entry <= head_entry;
        end
    end

    ////////////////////////////////////////
    // Write cycle timing.
    ////////////////////////////////////////
    // Pop cycle counts as the last high cycle of the previous word,
    // so WR_HIGH holds for WR_HIGH_CYCLES - 1 cycles.
    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            state  <= BW_IDLE;
            phase  <= 4'd0;
            lcd_cs <= 1'b1; // Deselected.
            lcd_wr <= 1'b1;
        end else begin
            case (state)
                BW_IDLE: begin
                    if (pop_en) begin
                        lcd_cs <= 1'b0; // Both fall the cycle after pop.
                        lcd_wr <= 1'b0;
                        phase  <= WR_LOW_CYCLES - 4'd1;
                        state  <= BW_WR_LOW;
                    end
                end
                BW_WR_LOW: begin
                    if (phase == 4'd0) begin
                        lcd_cs <= 1'b1; // Panel samples on this WR rise.
                        lcd_wr <= 1'b1;
                        phase  <= WR_HIGH_CYCLES - 4'd2;
                        state  <= BW_WR_HIGH;
                    end else begin
                        phase <= phase - 4'd1;
                    end
                end
                BW_WR_HIGH: begin
                    if (phase == 4'd0) state <= BW_IDLE;
                    else phase <= phase - 4'd1;
                end
                default: begin
                    lcd_cs <= 1'b1;
                    lcd_wr <= 1'b1;
                    state  <= BW_IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/lcd_cmd_fifo.sv */
`timescale 1ns/100ps

module lcd_cmd_fifo import lcd_pkg::*; (
    input  logic       clk_20MHz,
    input  logic       rst_n,
    input  logic       push_en,
    input  bus_entry_t push_entry,
    input  logic       pop_en,
    output bus_entry_t head_entry,
    output logic       full,
    output logic       empty
);

    bus_entry_t mem [FIFO_DEPTH];

    // One extra wrap bit on each pointer.
    logic [FIFO_ADDR_W:0] wr_ptr;
    logic [FIFO_ADDR_W:0] rd_ptr;
    logic                 do_push;
    logic                 do_pop;

    ////////////////////////////////////////
    // Level flags.
    ////////////////////////////////////////
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                   (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);

    // Overflow and underflow requests are dropped.
    assign do_push = push_en && !full;
    assign do_pop  = pop_en && !empty;

    // Head is visible without a read cycle.
    assign head_entry = mem[rd_ptr[FIFO_ADDR_W-1:0]];

    // Storage.
    always_ff @(posedge clk_20MHz) begin
        if (do_push) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= push_entry;
        end
    end

    ////////////////////////////////////////
    // Pointers.
    ////////////////////////////////////////
    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // Wraps through the extra bit.
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

/* rtl/lcd_pkg.sv */
package lcd_pkg;

    ////////////////////////////////////////
    // Panel command set.
    ////////////////////////////////////////
    localparam logic [7:0] CMD_SOFT_RESET   = 8'h01;
    localparam logic [7:0] CMD_SLEEP_OUT    = 8'h11;
    localparam logic [7:0] CMD_PIXEL_FORMAT = 8'h3A;
    localparam logic [7:0] CMD_DISPLAY_ON   = 8'h29;
    localparam logic [7:0] CMD_COLUMN_ADDR  = 8'h2A;
    localparam logic [7:0] CMD_PAGE_ADDR    = 8'h2B;
    localparam logic [7:0] CMD_MEMORY_WRITE = 8'h2C;

    // Parameter byte after CMD_PIXEL_FORMAT, RGB565 on both interfaces.
    localparam logic [7:0] PIXEL_FORMAT_16BIT = 8'h55;

    ////////////////////////////////////////
    // Timing, in clk_20MHz cycles.
    ////////////////////////////////////////
    localparam logic [15:0] RST_LOW_CYCLES  = 16'd8;  // Panel reset pulse.
    localparam logic [15:0] RST_WAIT_CYCLES = 16'd16; // Settle time after it.
    localparam logic [3:0]  WR_LOW_CYCLES   = 4'd2;   // WR strobe low phase.
    localparam logic [3:0]  WR_HIGH_CYCLES  = 4'd2;   // High phase, at least 2.

    // Command FIFO geometry. Depth must be a power of two.
    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    // Five-word runs. Init table and column/page address groups.
    localparam logic [2:0] SEQ_LAST_STEP = 3'd4;

    // Sequencer step codes.
    localparam logic [3:0] SEQ_RESET_LOW  = 4'd0;
    localparam logic [3:0] SEQ_RESET_WAIT = 4'd1;
    localparam logic [3:0] SEQ_INIT       = 4'd2;
    localparam logic [3:0] SEQ_IDLE       = 4'd3;
    localparam logic [3:0] SEQ_COLUMN     = 4'd4;
    localparam logic [3:0] SEQ_PAGE       = 4'd5;
    localparam logic [3:0] SEQ_MEMWRITE   = 4'd6;
    localparam logic [3:0] SEQ_PIXELS     = 4'd7;
    localparam logic [3:0] SEQ_DRAIN      = 4'd8;

    // Bus writer states.
    localparam logic [1:0] BW_IDLE    = 2'd0;
    localparam logic [1:0] BW_WR_LOW  = 2'd1;
    localparam logic [1:0] BW_WR_HIGH = 2'd2;

    ////////////////////////////////////////
    // Bus word and FIFO entry.
    ////////////////////////////////////////
    typedef struct packed {
        logic [7:0] rsvd; // Upper byte, zero on the bus.
        logic [7:0] code; // Command code.
    } lcd_cmd_view_t;

    // One 16-bit bus word, seen as raw data or as a command.
    typedef union packed {
        logic [15:0]   raw;
        lcd_cmd_view_t cmd;
    } lcd_word_u;

    typedef struct packed {
        logic      is_data; // Drives RS. Low for commands.
        lcd_word_u word;
    } bus_entry_t;

endpackage
